// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int NUM_ARCH_REGS = 32;
  localparam int OP_WIDTH      = 8;

  typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;

  // instruction class, also picks the op view
  typedef enum logic [2:0] {
    INSTR_ALU  = 3'd0,
    INSTR_MDU  = 3'd1,
    INSTR_MEM  = 3'd2,
    INSTR_MISC = 3'd3,
    INSTR_BR   = 3'd4,
    INSTR_PRIV = 3'd5
  } instr_type_t;

  typedef struct packed {
    logic [OP_WIDTH-1:0] alu_op;
  } alu_view_t;

  typedef struct packed {
    logic [2:0] mem_op;
    logic [4:0] cacop_code;
  } mem_view_t;

  typedef struct packed {
    logic [2:0] misc_op;
    logic [4:0] spare;
  } misc_view_t;

  typedef union packed {
    alu_view_t  alu;
    mem_view_t  mem;
    misc_view_t misc;
  } op_u;

  localparam logic [2:0] MEM_CACOP    = 3'd7;
  localparam logic [2:0] MISC_SYSCALL = 3'd1;
  localparam logic [2:0] MISC_BREAK   = 3'd2;

endpackage

`default_nettype wire

// File: logic/excp_pkg.sv
`default_nettype none

package excp_pkg;

  localparam int ECODE_WIDTH = 6;
  localparam int PLV_WIDTH   = 2;

  typedef logic [ECODE_WIDTH-1:0] ecode_t;
  typedef logic [PLV_WIDTH-1:0]   plv_t;

  // exception codes raised in rename
  localparam ecode_t ECODE_INT = 6'h00;
  localparam ecode_t ECODE_SYS = 6'h0b;
  localparam ecode_t ECODE_BRK = 6'h0c;
  localparam ecode_t ECODE_INE = 6'h0d;
  localparam ecode_t ECODE_IPE = 6'h0e;

  // least privileged level
  localparam plv_t PLV_USER = 2'd3;

endpackage

`default_nettype wire

// File: logic/free_list.sv
`default_nettype none

module free_list #(
  parameter int PHY_REG_NUM  = 64,
  parameter int DECODE_WIDTH = 2
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [DECODE_WIDTH-1:0]                       alloc_valid_i,
  output logic                                          alloc_ready_o,
  output logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] alloc_preg_o,
  input  logic [DECODE_WIDTH-1:0]                       free_valid_i,
  input  logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] free_preg_i
);

  import isa_pkg::*;

  localparam int PREG_W   = $clog2(PHY_REG_NUM);
  localparam int FL_DEPTH = PHY_REG_NUM - NUM_ARCH_REGS;
  localparam int PTR_W    = $clog2(FL_DEPTH);
  localparam int CNT_W    = $clog2(FL_DEPTH + 1);

  logic [PREG_W-1:0]                  fl_mem [FL_DEPTH];
  logic [PTR_W-1:0]                   head_q;
  logic [PTR_W-1:0]                   tail_q;
  logic [CNT_W-1:0]                   cnt_q;
  logic [CNT_W-1:0]                   alloc_cnt;
  logic [CNT_W-1:0]                   free_cnt;
  logic [DECODE_WIDTH-1:0][PTR_W-1:0] alloc_ptr;
  logic [DECODE_WIDTH-1:0][PTR_W-1:0] free_ptr;
  logic                               alloc_fire;

  // pointer advance with wrap at the buffer depth
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                               input logic [CNT_W-1:0] n);
    int sum;
    sum = int'(ptr) + int'(n);
    if (sum >= FL_DEPTH) begin
      sum = sum - FL_DEPTH;
    end
    return PTR_W'(sum);
  endfunction

  // slots take consecutive entries, skipping idle slots
  always_comb begin
    alloc_cnt = '0;
    free_cnt  = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      alloc_ptr[i]    = ptr_add(head_q, alloc_cnt);
      free_ptr[i]     = ptr_add(tail_q, free_cnt);
      alloc_preg_o[i] = fl_mem[alloc_ptr[i]];
      alloc_cnt       = alloc_cnt + CNT_W'(alloc_valid_i[i]);
      free_cnt        = free_cnt + CNT_W'(free_valid_i[i]);
    end
    alloc_ready_o = (cnt_q >= alloc_cnt);
    alloc_fire    = alloc_ready_o & (|alloc_valid_i);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= CNT_W'(FL_DEPTH);
      // registers above the architectural ones start out free
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem[i] <= PREG_W'(NUM_ARCH_REGS + i);
      end
    end else begin
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        if (free_valid_i[i]) begin
          fl_mem[free_ptr[i]] <= free_preg_i[i];
        end
      end
      if (alloc_fire) begin
        head_q <= ptr_add(head_q, alloc_cnt);
      end
      tail_q <= ptr_add(tail_q, free_cnt);
      cnt_q  <= cnt_q - (alloc_fire ? alloc_cnt : CNT_W'(0)) + free_cnt;
    end
  end

endmodule

`default_nettype wire

// File: logic/reg_alias_table.sv
`default_nettype none

module reg_alias_table #(
  parameter int PHY_REG_NUM  = 64,
  parameter int DECODE_WIDTH = 2
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          update_i,
  input  logic [DECODE_WIDTH-1:0]                       dest_valid_i,
  input  isa_pkg::arch_reg_t [DECODE_WIDTH-1:0]         src0_i,
  input  isa_pkg::arch_reg_t [DECODE_WIDTH-1:0]         src1_i,
  input  isa_pkg::arch_reg_t [DECODE_WIDTH-1:0]         dest_i,
  input  logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] preg_i,
  output logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] psrc0_o,
  output logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] psrc1_o,
  output logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] old_pdest_o
);

  import isa_pkg::*;

  localparam int PREG_W = $clog2(PHY_REG_NUM);

  logic [PREG_W-1:0]       map_q [NUM_ARCH_REGS];
  logic [DECODE_WIDTH-1:0] wr_en;

  // r0 is hardwired, never remapped
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      wr_en[i] = dest_valid_i[i] & (|dest_i[i]);
    end
  end

  // table read, then earlier slots of the group override in slot order
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      psrc0_o[i]     = map_q[src0_i[i]];
      psrc1_o[i]     = map_q[src1_i[i]];
      old_pdest_o[i] = map_q[dest_i[i]];
      for (int j = 0; j < i; j++) begin
        if (wr_en[j] && (dest_i[j] == src0_i[i])) begin
          psrc0_o[i] = preg_i[j];
        end
        if (wr_en[j] && (dest_i[j] == src1_i[i])) begin
          psrc1_o[i] = preg_i[j];
        end
        if (wr_en[j] && (dest_i[j] == dest_i[i])) begin
          old_pdest_o[i] = preg_i[j];
        end
      end
    end
  end

  // later slot wins on a shared destination
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_ARCH_REGS; r++) begin
        map_q[r] <= PREG_W'(r);
      end
    end else if (update_i) begin
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        if (wr_en[i]) begin
          map_q[dest_i[i]] <= preg_i[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/excp_check.sv
`default_nettype none

module excp_check #(
  parameter int DECODE_WIDTH = 2
) (
  input  logic [DECODE_WIDTH-1:0]               valid_i,
  input  isa_pkg::instr_type_t [DECODE_WIDTH-1:0] instr_type_i,
  input  isa_pkg::op_u [DECODE_WIDTH-1:0]         op_i,
  input  logic [DECODE_WIDTH-1:0]               fetch_excp_i,
  input  excp_pkg::ecode_t [DECODE_WIDTH-1:0]     fetch_ecode_i,
  input  logic [DECODE_WIDTH-1:0]               invalid_i,
  input  logic                                  csr_has_int_i,
  input  excp_pkg::plv_t                        csr_plv_i,
  output logic [DECODE_WIDTH-1:0]               excp_valid_o,
  output excp_pkg::ecode_t [DECODE_WIDTH-1:0]     ecode_o
);

  import isa_pkg::*;
  import excp_pkg::*;

  logic [DECODE_WIDTH-1:0] priv_instr;
  logic [DECODE_WIDTH-1:0] syscall_instr;
  logic [DECODE_WIDTH-1:0] break_instr;

  // cacop with code[4:3] == 2'b10 is allowed at user level
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      priv_instr[i] = (instr_type_i[i] == INSTR_PRIV) |
                      ((instr_type_i[i] == INSTR_MEM) &
                       (op_i[i].mem.mem_op == MEM_CACOP) &
                       (op_i[i].mem.cacop_code[4:3] != 2'b10));
      syscall_instr[i] = (instr_type_i[i] == INSTR_MISC) &
                         (op_i[i].misc.misc_op == MISC_SYSCALL);
      break_instr[i]   = (instr_type_i[i] == INSTR_MISC) &
                         (op_i[i].misc.misc_op == MISC_BREAK);
    end
  end

  // INT > fetch > INE > IPE > SYS > BRK
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      excp_valid_o[i] = valid_i[i];
      ecode_o[i]      = '0;
      if (!valid_i[i]) begin
        excp_valid_o[i] = 1'b0;
      end else if (csr_has_int_i) begin
        ecode_o[i] = ECODE_INT;
      end else if (fetch_excp_i[i]) begin
        ecode_o[i] = fetch_ecode_i[i];
      end else if (invalid_i[i]) begin
        ecode_o[i] = ECODE_INE;
      end else if (priv_instr[i] && (csr_plv_i == PLV_USER)) begin
        ecode_o[i] = ECODE_IPE;
      end else if (syscall_instr[i]) begin
        ecode_o[i] = ECODE_SYS;
      end else if (break_instr[i]) begin
        ecode_o[i] = ECODE_BRK;
      end else begin
        excp_valid_o[i] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/rename_stage.sv
`default_nettype none

module rename_stage #(
  parameter int PHY_REG_NUM  = 64,
  parameter int DECODE_WIDTH = 2
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  // decoded group in
  input  logic [DECODE_WIDTH-1:0]                       in_valid_i,
  input  isa_pkg::instr_type_t [DECODE_WIDTH-1:0]       in_instr_type_i,
  input  isa_pkg::op_u [DECODE_WIDTH-1:0]               in_op_i,
  input  isa_pkg::arch_reg_t [DECODE_WIDTH-1:0]         in_arch_src0_i,
  input  isa_pkg::arch_reg_t [DECODE_WIDTH-1:0]         in_arch_src1_i,
  input  isa_pkg::arch_reg_t [DECODE_WIDTH-1:0]         in_arch_dest_i,
  input  logic [DECODE_WIDTH-1:0]                       in_fetch_excp_i,
  input  excp_pkg::ecode_t [DECODE_WIDTH-1:0]           in_fetch_ecode_i,
  input  logic [DECODE_WIDTH-1:0]                       in_invalid_i,
  output logic                                          in_ready_o,
  // csr levels and commit frees
  input  logic                                          csr_has_int_i,
  input  excp_pkg::plv_t                                csr_plv_i,
  input  logic [DECODE_WIDTH-1:0]                       free_valid_i,
  input  logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] free_preg_i,
  // renamed group to the ROB
  input  logic                                          rob_ready_i,
  output logic [DECODE_WIDTH-1:0]                       out_valid_o,
  output logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] out_psrc0_o,
  output logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] out_psrc1_o,
  output logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] out_pdest_o,
  output logic [DECODE_WIDTH-1:0]                       out_pdest_valid_o,
  output logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] out_old_pdest_o,
  output logic [DECODE_WIDTH-1:0]                       out_excp_valid_o,
  output excp_pkg::ecode_t [DECODE_WIDTH-1:0]           out_ecode_o
);

  import isa_pkg::*;
  import excp_pkg::*;

  localparam int PREG_W = $clog2(PHY_REG_NUM);

  logic                                s1_ready;
  logic                                rob_fire;
  logic                                fl_alloc_ready;
  logic [DECODE_WIDTH-1:0]             fl_alloc_valid;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] fl_alloc_preg;

  // ==========================================================================
  // stage 0: accept group, allocate destinations
  // ==========================================================================

  // stage 1 empty or draining this edge
  assign s1_ready   = rob_ready_i | ~(|out_valid_o);
  assign in_ready_o = s1_ready & fl_alloc_ready;

  // no register for faulting, invalid or r0 destinations
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      fl_alloc_valid[i] = in_valid_i[i] & ~in_fetch_excp_i[i] & ~in_invalid_i[i] &
                          (|in_arch_dest_i[i]) & s1_ready;
    end
  end

  free_list #(
    .PHY_REG_NUM  (PHY_REG_NUM),
    .DECODE_WIDTH (DECODE_WIDTH)
  ) free_list_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .alloc_valid_i (fl_alloc_valid),
    .alloc_ready_o (fl_alloc_ready),
    .alloc_preg_o  (fl_alloc_preg),
    .free_valid_i  (free_valid_i),
    .free_preg_i   (free_preg_i)
  );

  // ==========================================================================
  // stage 1: group register, RAT lookup, exception check
  // ==========================================================================
  instr_type_t [DECODE_WIDTH-1:0]      s1_instr_type_q;
  op_u [DECODE_WIDTH-1:0]              s1_op_q;
  arch_reg_t [DECODE_WIDTH-1:0]        s1_src0_q;
  arch_reg_t [DECODE_WIDTH-1:0]        s1_src1_q;
  arch_reg_t [DECODE_WIDTH-1:0]        s1_dest_q;
  logic [DECODE_WIDTH-1:0]             s1_fetch_excp_q;
  ecode_t [DECODE_WIDTH-1:0]           s1_fetch_ecode_q;
  logic [DECODE_WIDTH-1:0]             s1_invalid_q;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] s1_preg_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o       <= '0;
      out_pdest_valid_o <= '0;
    end else if (in_ready_o) begin
      out_valid_o       <= in_valid_i;
      out_pdest_valid_o <= fl_alloc_valid;
    end else if (rob_ready_i) begin
      // drained with nothing behind it
      out_valid_o       <= '0;
      out_pdest_valid_o <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready_o) begin
      s1_instr_type_q  <= in_instr_type_i;
      s1_op_q          <= in_op_i;
      s1_src0_q        <= in_arch_src0_i;
      s1_src1_q        <= in_arch_src1_i;
      s1_dest_q        <= in_arch_dest_i;
      s1_fetch_excp_q  <= in_fetch_excp_i;
      s1_fetch_ecode_q <= in_fetch_ecode_i;
      s1_invalid_q     <= in_invalid_i;
      s1_preg_q        <= fl_alloc_preg;
    end
  end

  // map commits with the ROB handoff
  assign rob_fire    = rob_ready_i & (|out_valid_o);
  assign out_pdest_o = s1_preg_q;

  reg_alias_table #(
    .PHY_REG_NUM  (PHY_REG_NUM),
    .DECODE_WIDTH (DECODE_WIDTH)
  ) reg_alias_table_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .update_i     (rob_fire),
    .dest_valid_i (out_pdest_valid_o),
    .src0_i       (s1_src0_q),
    .src1_i       (s1_src1_q),
    .dest_i       (s1_dest_q),
    .preg_i       (s1_preg_q),
    .psrc0_o      (out_psrc0_o),
    .psrc1_o      (out_psrc1_o),
    .old_pdest_o  (out_old_pdest_o)
  );

  excp_check #(
    .DECODE_WIDTH (DECODE_WIDTH)
  ) excp_check_i (
    .valid_i       (out_valid_o),
    .instr_type_i  (s1_instr_type_q),
    .op_i          (s1_op_q),
    .fetch_excp_i  (s1_fetch_excp_q),
    .fetch_ecode_i (s1_fetch_ecode_q),
    .invalid_i     (s1_invalid_q),
    .csr_has_int_i (csr_has_int_i),
    .csr_plv_i     (csr_plv_i),
    .excp_valid_o  (out_excp_valid_o),
    .ecode_o       (out_ecode_o)
  );

endmodule

`default_nettype wire

// File: dv/rename_assertions.sv
`default_nettype none

module rename_assertions #(
  parameter int PHY_REG_NUM  = 64,
  parameter int DECODE_WIDTH = 2
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             rob_ready_i,
  input  logic [DECODE_WIDTH-1:0]                          out_valid_o,
  input  logic [DECODE_WIDTH-1:0]                          out_pdest_valid_o,
  input  logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] out_pdest_o,
  input  logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] out_psrc0_o,
  input  logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] out_psrc1_o,
  input  logic [DECODE_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0] out_old_pdest_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // stalled group must not move
  hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
    ((|out_valid_o) && !rob_ready_i) |=> ($stable(out_valid_o) && $stable(out_pdest_o) &&
      $stable(out_pdest_valid_o) && $stable(out_psrc0_o) && $stable(out_psrc1_o) &&
      $stable(out_old_pdest_o)))
    else begin
      $error("renamed group changed while the reorder buffer was stalled");
      fail_count = fail_count + 1;
    end

  quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (out_valid_o == '0))
    else begin
      $error("output group valid while reset is asserted");
      fail_count = fail_count + 1;
    end

  for (genvar i = 0; i < DECODE_WIDTH; i++) begin : g_pdest
    no_zero_pdest: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid_o[i] && out_pdest_valid_o[i]) |-> (out_pdest_o[i] != '0))
      else begin
        $error("slot %0d was given physical register 0 as destination", i);
        fail_count = fail_count + 1;
      end
  end

endmodule

`default_nettype wire

// File: dv/rename_tb.sv
`default_nettype none

module rename_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import isa_pkg::*;
  import excp_pkg::*;

  localparam int PHY_REG_NUM  = 64;
  localparam int DECODE_WIDTH = 2;
  localparam int PREG_W       = $clog2(PHY_REG_NUM);
  localparam int RESET_CYCLES = 10;
  // rough cycle budget per test in run order
  localparam int TEST_CYCLES  = 5 + 10 + 10 + 20 + 15 + 120;

  typedef struct packed {
    logic [DECODE_WIDTH-1:0]             valid;
    logic [DECODE_WIDTH-1:0][PREG_W-1:0] psrc0;
    logic [DECODE_WIDTH-1:0][PREG_W-1:0] psrc1;
    logic [DECODE_WIDTH-1:0][PREG_W-1:0] pdest;
    logic [DECODE_WIDTH-1:0][PREG_W-1:0] old;
    logic [DECODE_WIDTH-1:0]             pdv;
    logic [DECODE_WIDTH-1:0]             ev;
    ecode_t [DECODE_WIDTH-1:0]           ec;
  } exp_t;

  logic clk;
  logic rst_n;
  logic [DECODE_WIDTH-1:0] in_valid;
  instr_type_t [DECODE_WIDTH-1:0] in_type;
  op_u [DECODE_WIDTH-1:0] in_op;
  arch_reg_t [DECODE_WIDTH-1:0] in_src0;
  arch_reg_t [DECODE_WIDTH-1:0] in_src1;
  arch_reg_t [DECODE_WIDTH-1:0] in_dest;
  logic [DECODE_WIDTH-1:0] in_fexcp;
  ecode_t [DECODE_WIDTH-1:0] in_fecode;
  logic [DECODE_WIDTH-1:0] in_invalid;
  logic in_ready;
  logic csr_has_int;
  plv_t csr_plv;
  logic [DECODE_WIDTH-1:0] free_valid;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] free_preg;
  logic rob_ready;
  logic [DECODE_WIDTH-1:0] out_valid;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] out_psrc0;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] out_psrc1;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] out_pdest;
  logic [DECODE_WIDTH-1:0] out_pdest_valid;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] out_old_pdest;
  logic [DECODE_WIDTH-1:0] out_excp_valid;
  ecode_t [DECODE_WIDTH-1:0] out_ecode;

  int errors = 0;
  logic [PREG_W-1:0] map_model [NUM_ARCH_REGS];
  logic [PREG_W-1:0] free_q [$];
  exp_t exp_q [$];

  rename_stage #(
    .PHY_REG_NUM  (PHY_REG_NUM),
    .DECODE_WIDTH (DECODE_WIDTH)
  ) rename_stage_i (
    .clk (clk), .rst_n (rst_n),
    .in_valid_i (in_valid), .in_instr_type_i (in_type), .in_op_i (in_op),
    .in_arch_src0_i (in_src0), .in_arch_src1_i (in_src1), .in_arch_dest_i (in_dest),
    .in_fetch_excp_i (in_fexcp), .in_fetch_ecode_i (in_fecode),
    .in_invalid_i (in_invalid), .in_ready_o (in_ready),
    .csr_has_int_i (csr_has_int), .csr_plv_i (csr_plv),
    .free_valid_i (free_valid), .free_preg_i (free_preg), .rob_ready_i (rob_ready),
    .out_valid_o (out_valid), .out_psrc0_o (out_psrc0), .out_psrc1_o (out_psrc1),
    .out_pdest_o (out_pdest), .out_pdest_valid_o (out_pdest_valid),
    .out_old_pdest_o (out_old_pdest), .out_excp_valid_o (out_excp_valid),
    .out_ecode_o (out_ecode)
  );

  bind rename_stage rename_assertions #(
    .PHY_REG_NUM  (PHY_REG_NUM),
    .DECODE_WIDTH (DECODE_WIDTH)
  ) rename_assertions_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic compare_preg(string name, logic [PREG_W-1:0] got, logic [PREG_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_ecode(string name, ecode_t got, ecode_t exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // ==========================================================================
  // stimulus and scoreboard
  // ==========================================================================
  task automatic clear_group();
    in_valid   = '0;
    in_type    = '{default: INSTR_ALU};
    in_op      = '0;
    in_src0    = '0;
    in_src1    = '0;
    in_dest    = '0;
    in_fexcp   = '0;
    in_fecode  = '0;
    in_invalid = '0;
  endtask

  task automatic set_slot(int i, instr_type_t t, op_u op, arch_reg_t s0, arch_reg_t s1,
                          arch_reg_t d, logic fe, ecode_t fc, logic inv);
    in_valid[i]   = 1'b1;
    in_type[i]    = t;
    in_op[i]      = op;
    in_src0[i]    = s0;
    in_src1[i]    = s1;
    in_dest[i]    = d;
    in_fexcp[i]   = fe;
    in_fecode[i]  = fc;
    in_invalid[i] = inv;
  endtask

  // fixed priority from the exception rules
  task automatic expect_excp(int i, output logic ev, output ecode_t ec);
    logic priv;
    priv = (in_type[i] == INSTR_PRIV) || ((in_type[i] == INSTR_MEM) &&
           (in_op[i][7:5] == MEM_CACOP) && (in_op[i][4:3] != 2'b10));
    ev = 1'b1;
    ec = '0;
    if (csr_has_int) ec = ECODE_INT;
    else if (in_fexcp[i]) ec = in_fecode[i];
    else if (in_invalid[i]) ec = ECODE_INE;
    else if (priv && (csr_plv == PLV_USER)) ec = ECODE_IPE;
    else if ((in_type[i] == INSTR_MISC) && (in_op[i][7:5] == MISC_SYSCALL)) ec = ECODE_SYS;
    else if ((in_type[i] == INSTR_MISC) && (in_op[i][7:5] == MISC_BREAK)) ec = ECODE_BRK;
    else ev = 1'b0;
  endtask

  // slots processed in order so later slots see earlier writes
  task automatic predict_group();
    exp_t e;
    e = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      if (in_valid[i]) begin
        e.valid[i] = 1'b1;
        e.psrc0[i] = map_model[in_src0[i]];
        e.psrc1[i] = map_model[in_src1[i]];
        e.old[i]   = map_model[in_dest[i]];
        e.pdv[i]   = !in_fexcp[i] && !in_invalid[i] && (in_dest[i] != '0);
        if (e.pdv[i]) begin
          e.pdest[i] = free_q.pop_front();
          map_model[in_dest[i]] = e.pdest[i];
        end
        expect_excp(i, e.ev[i], e.ec[i]);
      end
    end
    exp_q.push_back(e);
  endtask

  task automatic send_group();
    while (!in_ready) @(negedge clk);
    predict_group();
    @(posedge clk);
    @(negedge clk);
    in_valid = '0;
  endtask

  task automatic check_group();
    exp_t e;
    while (!(|out_valid)) @(negedge clk);
    if (exp_q.size() == 0) begin
      $display("output group appeared with no group pending");
      errors++;
    end else begin
      e = exp_q.pop_front();
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        compare_flag($sformatf("out_valid_o[%0d]", i), out_valid[i], e.valid[i]);
        compare_flag($sformatf("out_pdest_valid_o[%0d]", i), out_pdest_valid[i], e.pdv[i]);
        compare_flag($sformatf("out_excp_valid_o[%0d]", i), out_excp_valid[i], e.ev[i]);
        if (e.valid[i]) begin
          compare_preg($sformatf("out_psrc0_o[%0d]", i), out_psrc0[i], e.psrc0[i]);
          compare_preg($sformatf("out_psrc1_o[%0d]", i), out_psrc1[i], e.psrc1[i]);
          compare_preg($sformatf("out_old_pdest_o[%0d]", i), out_old_pdest[i], e.old[i]);
        end
        if (e.pdv[i]) compare_preg($sformatf("out_pdest_o[%0d]", i), out_pdest[i], e.pdest[i]);
        if (e.ev[i]) compare_ecode($sformatf("out_ecode_o[%0d]", i), out_ecode[i], e.ec[i]);
      end
    end
    rob_ready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    in_valid = '0;
  endtask

  task automatic run_one(int i0, instr_type_t t0, op_u op0, arch_reg_t d0,
                         int i1, instr_type_t t1, op_u op1, arch_reg_t d1);
    clear_group();
    set_slot(0, t0, op0, 5'd1, 5'd2, d0, 1'b0, '0, i0[0]);
    set_slot(1, t1, op1, 5'd3, 5'd4, d1, 1'b0, '0, i1[0]);
    send_group();
    check_group();
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================
  task automatic test_identity();
    clear_group();
    set_slot(0, INSTR_ALU, '0, 5'd5, 5'd7, 5'd0, 1'b0, '0, 1'b0);
    set_slot(1, INSTR_ALU, '0, 5'd31, 5'd0, 5'd0, 1'b0, '0, 1'b0);
    send_group();
    compare_flag("out_valid_o[0]", out_valid[0], 1'b1);
    check_group();
  endtask

  task automatic test_alloc();
    clear_group();
    set_slot(0, INSTR_ALU, '0, 5'd1, 5'd2, 5'd3, 1'b0, '0, 1'b0);
    set_slot(1, INSTR_MDU, '0, 5'd5, 5'd6, 5'd4, 1'b0, '0, 1'b0);
    send_group();
    check_group();
    clear_group();
    set_slot(0, INSTR_ALU, '0, 5'd3, 5'd4, 5'd3, 1'b0, '0, 1'b0);
    send_group();
    check_group();
  endtask

  task automatic test_bypass();
    clear_group();
    set_slot(0, INSTR_ALU, '0, 5'd1, 5'd2, 5'd10, 1'b0, '0, 1'b0);
    set_slot(1, INSTR_ALU, '0, 5'd10, 5'd10, 5'd10, 1'b0, '0, 1'b0);
    send_group();
    check_group();
    clear_group();
    set_slot(0, INSTR_ALU, '0, 5'd10, 5'd3, 5'd0, 1'b0, '0, 1'b0);
    send_group();
    check_group();
  endtask

  task automatic test_excp();
    csr_has_int = 1'b1;
    clear_group();
    set_slot(0, INSTR_ALU, '0, 5'd1, 5'd2, 5'd0, 1'b1, 6'h08, 1'b0);
    set_slot(1, INSTR_MISC, op_u'({MISC_SYSCALL, 5'd0}), 5'd1, 5'd2, 5'd0, 1'b0, '0, 1'b0);
    send_group();
    check_group();
    csr_has_int = 1'b0;
    clear_group();
    set_slot(0, INSTR_ALU, '0, 5'd1, 5'd2, 5'd9, 1'b1, 6'h08, 1'b1);
    set_slot(1, INSTR_PRIV, '0, 5'd1, 5'd2, 5'd0, 1'b0, '0, 1'b1);
    send_group();
    check_group();
    run_one(0, INSTR_MEM, op_u'({MEM_CACOP, 5'b01000}), 5'd0,
            0, INSTR_MEM, op_u'({MEM_CACOP, 5'b10000}), 5'd0);
    run_one(0, INSTR_MISC, op_u'({MISC_BREAK, 5'd0}), 5'd0,
            1, INSTR_MISC, op_u'({MISC_SYSCALL, 5'd0}), 5'd0);
    csr_plv = 2'd0;
    run_one(0, INSTR_PRIV, '0, 5'd0, 0, INSTR_MISC, op_u'({MISC_SYSCALL, 5'd0}), 5'd0);
    csr_plv = PLV_USER;
  endtask

  task automatic test_backpressure();
    exp_t held;
    rob_ready = 1'b0;
    clear_group();
    set_slot(0, INSTR_ALU, '0, 5'd3, 5'd10, 5'd11, 1'b0, '0, 1'b0);
    set_slot(1, INSTR_ALU, '0, 5'd11, 5'd4, 5'd12, 1'b0, '0, 1'b0);
    send_group();
    held = exp_q[0];
    clear_group();
    set_slot(0, INSTR_ALU, '0, 5'd11, 5'd12, 5'd11, 1'b0, '0, 1'b0);
    set_slot(1, INSTR_ALU, '0, 5'd12, 5'd11, 5'd13, 1'b0, '0, 1'b0);
    repeat (3) begin
      @(negedge clk);
      compare_flag("in_ready_o", in_ready, 1'b0);
      compare_preg("out_pdest_o[1]", out_pdest[1], held.pdest[1]);
    end
    predict_group();
    check_group();
    check_group();
  endtask

  task automatic test_exhaustion();
    while (free_q.size() > 0) begin
      clear_group();
      set_slot(0, INSTR_ALU, '0, 5'd5, 5'd6, 5'd5, 1'b0, '0, 1'b0);
      if (free_q.size() >= 2) set_slot(1, INSTR_ALU, '0, 5'd5, 5'd6, 5'd6, 1'b0, '0, 1'b0);
      send_group();
      check_group();
    end
    clear_group();
    set_slot(0, INSTR_ALU, '0, 5'd7, 5'd8, 5'd7, 1'b0, '0, 1'b0);
    set_slot(1, INSTR_ALU, '0, 5'd7, 5'd8, 5'd8, 1'b0, '0, 1'b0);
    repeat (3) begin
      @(negedge clk);
      compare_flag("in_ready_o", in_ready, 1'b0);
    end
    free_valid = 2'b11;
    free_preg  = {6'd50, 6'd45};
    free_q.push_back(6'd45);
    free_q.push_back(6'd50);
    @(negedge clk);
    free_valid = '0;
    send_group();
    check_group();
  endtask

  initial begin
    #((RESET_CYCLES + 2 * TEST_CYCLES) * 40);
    $display("watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int assert_fails;
    rst_n       = 1'b0;
    rob_ready   = 1'b1;
    csr_has_int = 1'b0;
    csr_plv     = PLV_USER;
    free_valid  = '0;
    free_preg   = '0;
    clear_group();
    for (int r = 0; r < NUM_ARCH_REGS; r++) map_model[r] = PREG_W'(r);
    for (int p = NUM_ARCH_REGS; p < PHY_REG_NUM; p++) free_q.push_back(PREG_W'(p));
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    compare_flag("in_ready_o", in_ready, 1'b1);
    test_identity();
    test_alloc();
    test_bypass();
    test_excp();
    test_backpressure();
    test_exhaustion();
    assert_fails = rename_stage_i.rename_assertions_i.fail_count;
    $display("compare errors: %0d  assertion failures: %0d", errors, assert_fails);
    if ((errors == 0) && (assert_fails == 0)) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
logic/isa_pkg.sv
logic/excp_pkg.sv
logic/free_list.sv
logic/reg_alias_table.sv
logic/excp_check.sv
logic/rename_stage.sv
dv/rename_assertions.sv
dv/rename_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= rename_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
